// File: src/icache_defs.svh
//--------------------------------------------------------------------------
// Instruction cache geometry and bus width constants
//--------------------------------------------------------------------------

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Byte address and data word widths
`define ICACHE_ADDR_W          16
`define ICACHE_WORD_W          32

// Line and array geometry, 1 KB in total
`define ICACHE_WORDS_PER_LINE  4
`define ICACHE_SETS            16
`define ICACHE_WAYS            4

`endif

// File: src/icache_pkg.sv
//--------------------------------------------------------------------------
// Instruction cache types: address fields, way, LRU age, line, word
// and the controller state encoding
//--------------------------------------------------------------------------

`include "icache_defs.svh"

package icache_pkg;

    // Field widths derived from the geometry
    localparam int word_bytes = `ICACHE_WORD_W / 8;
    localparam int offset_w   = $clog2(`ICACHE_WORDS_PER_LINE * word_bytes);
    localparam int sel_w      = $clog2(`ICACHE_WORDS_PER_LINE);
    localparam int index_w    = $clog2(`ICACHE_SETS);
    localparam int tag_w      = `ICACHE_ADDR_W - index_w - offset_w;
    localparam int way_w      = $clog2(`ICACHE_WAYS);

    typedef logic [`ICACHE_ADDR_W-1:0]                        addr_t;
    typedef logic [tag_w-1:0]                                 tag_t;
    typedef logic [index_w-1:0]                               index_t;
    typedef logic [sel_w-1:0]                                 word_sel_t;
    typedef logic [way_w-1:0]                                 way_t;
    typedef logic [way_w-1:0]                                 lru_age_t;
    typedef logic [`ICACHE_WORDS_PER_LINE*`ICACHE_WORD_W-1:0] line_t;
    typedef logic [`ICACHE_WORD_W-1:0]                        word_t;

    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_fill,
        st_respond
    } ctrl_state_t;

endpackage

// File: src/icache_lookup_if.sv
//--------------------------------------------------------------------------
// Lookup bus between the cache controller and the tag and LRU store
//--------------------------------------------------------------------------

interface icache_lookup_if
    import icache_pkg::*;
();

    // Set and tag of the request held by the controller
    index_t index;
    tag_t   tag;

    // Lookup result, combinational from index and tag
    logic   hit;
    way_t   hit_way;
    way_t   victim_way;

    // Update strobes, applied at the next edge
    logic   touch;
    logic   fill;

    modport ctrl (
        output index,
        output tag,
        output touch,
        output fill,
        input  hit,
        input  hit_way,
        input  victim_way
    );

    modport store (
        input  index,
        input  tag,
        input  touch,
        input  fill,
        output hit,
        output hit_way,
        output victim_way
    );

endinterface

// File: src/icache_ctrl.sv
//--------------------------------------------------------------------------
// Cache controller: request/response handshake, lookup FSM,
// fill sequencing and hit/miss counters
//--------------------------------------------------------------------------

`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  addr_t       req_addr,
    input  logic        line_done,
    input  line_t       fill_line,
    input  word_t       rd_word,
    output logic        req_ready,
    output logic        resp_valid,
    output word_t       resp_data,
    output logic        fill_start,
    output addr_t       fill_base,
    output logic        wr_en,
    output way_t        wr_way,
    output line_t       wr_line,
    output way_t        rd_way,
    output word_sel_t   rd_sel,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count,
    icache_lookup_if.ctrl lookup
);

    ctrl_state_t state;
    addr_t       addr_q;
    way_t        victim_q;
    logic        from_fill;
    word_t       miss_word;
    word_sel_t   word_sel;
    logic        fill_done;

    // Address fields of the accepted request
    assign lookup.tag   = addr_q[`ICACHE_ADDR_W-1 -: tag_w];
    assign lookup.index = addr_q[offset_w +: index_w];
    assign word_sel     = addr_q[offset_w-1 -: sel_w];

    assign fill_done    = (state == st_fill) && line_done;
    assign lookup.touch = (state == st_check) && lookup.hit;
    assign lookup.fill  = fill_done;

    assign req_ready  = (state == st_idle);
    assign fill_start = (state == st_check) && !lookup.hit;
    assign fill_base  = {addr_q[`ICACHE_ADDR_W-1:offset_w], {offset_w{1'b0}}};

    // Data store side
    assign wr_en   = fill_done;
    assign wr_way  = victim_q;
    assign wr_line = fill_line;
    assign rd_way  = lookup.hit_way;
    assign rd_sel  = word_sel;

    assign resp_data = from_fill ? miss_word : rd_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            addr_q     <= '0;
            victim_q   <= '0;
            from_fill  <= 1'b0;
            resp_valid <= 1'b0;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        addr_q <= req_addr;
                        state  <= st_check;
                    end
                end
                st_check: begin
                    if (lookup.hit) begin
                        hit_count  <= hit_count + 32'd1;
                        from_fill  <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= st_respond;
                    end else begin
                        miss_count <= miss_count + 32'd1;
                        victim_q   <= lookup.victim_way;
                        state      <= st_fill;
                    end
                end
                st_fill: begin
                    if (line_done) begin
                        from_fill  <= 1'b1;
                        resp_valid <= 1'b1;
                        state      <= st_respond;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Requested word taken straight from the incoming line
    always_ff @(posedge clk) begin
        if (fill_done) begin
            miss_word <= fill_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
        end
    end

    a_resp_single: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |=> !resp_valid
    ) else $error("resp_valid high for two cycles");

endmodule

// File: src/icache_tag_lru.sv
//--------------------------------------------------------------------------
// Tag, valid and LRU age arrays with parallel hit detection
// and victim selection
//--------------------------------------------------------------------------

`include "icache_defs.svh"

module icache_tag_lru
    import icache_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    icache_lookup_if.store lookup
);

    tag_t     tag_mem   [`ICACHE_SETS][`ICACHE_WAYS];
    logic     valid_mem [`ICACHE_SETS][`ICACHE_WAYS];
    lru_age_t age_mem   [`ICACHE_SETS][`ICACHE_WAYS];

    logic [`ICACHE_WAYS-1:0] hit_vec;
    way_t                    hit_way_c;
    way_t                    victim_c;
    way_t                    chosen_way;
    logic                    update;

    // Compare all ways of the set at once
    always_comb begin
        hit_vec   = '0;
        hit_way_c = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_vec[w] = valid_mem[lookup.index][w] &&
                         (tag_mem[lookup.index][w] == lookup.tag);
        end
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way_c = way_t'(w);
            end
        end
    end

    // Oldest way unless the lowest invalid way is free
    always_comb begin
        victim_c = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (age_mem[lookup.index][w] == lru_age_t'(`ICACHE_WAYS - 1)) begin
                victim_c = way_t'(w);
            end
        end
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_mem[lookup.index][w]) begin
                victim_c = way_t'(w);
            end
        end
    end

    assign lookup.hit        = |hit_vec;
    assign lookup.hit_way    = hit_way_c;
    assign lookup.victim_way = victim_c;

    assign chosen_way = lookup.fill ? victim_c : hit_way_c;
    assign update     = lookup.touch || lookup.fill;

    //--------------------------------------------------------------------------
    // Valid bits and ages
    //--------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    valid_mem[s][w] <= 1'b0;
                    age_mem[s][w]   <= lru_age_t'(w);
                end
            end
        end else if (update) begin
            // Ways younger than the chosen one grow older
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (age_mem[lookup.index][w] < age_mem[lookup.index][chosen_way]) begin
                    age_mem[lookup.index][w] <= age_mem[lookup.index][w] + 1'b1;
                end
            end
            age_mem[lookup.index][chosen_way] <= '0;
            if (lookup.fill) begin
                valid_mem[lookup.index][victim_c] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.fill) begin
            tag_mem[lookup.index][victim_c] <= lookup.tag;
        end
    end

    a_one_hit: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(hit_vec)
    ) else $error("more than one way hits");

endmodule

// File: src/icache_data_store.sv
//--------------------------------------------------------------------------
// Line data array: whole-line write on fill, registered word read
//--------------------------------------------------------------------------

`include "icache_defs.svh"

module icache_data_store
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  index_t    wr_set,
    input  way_t      wr_way,
    input  line_t     wr_line,
    input  index_t    rd_set,
    input  way_t      rd_way,
    input  word_sel_t rd_sel,
    output word_t     rd_word
);

    line_t line_mem [`ICACHE_SETS][`ICACHE_WAYS];
    line_t rd_line;

    assign rd_line = line_mem[rd_set][rd_way];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_set][wr_way] <= wr_line;
        end
    end

    // One cycle read of the selected word
    always_ff @(posedge clk) begin
        rd_word <= rd_line[rd_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
    end

endmodule

// File: src/icache_line_fill.sv
//--------------------------------------------------------------------------
// Wishbone classic read master: four single reads per line,
// assembled in order from offset 0
//--------------------------------------------------------------------------

`include "icache_defs.svh"

module icache_line_fill
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fill_start,
    input  addr_t fill_base,
    input  word_t wb_dat_i,
    input  logic  wb_ack,
    output logic  wb_cyc,
    output logic  wb_stb,
    output addr_t wb_adr,
    output logic  line_done,
    output line_t fill_line
);

    logic [`ICACHE_ADDR_W-offset_w-1:0] line_base_q;
    word_sel_t                          beat;
    line_t                              line_q;
    logic                               last_beat;

    assign last_beat = (beat == word_sel_t'(`ICACHE_WORDS_PER_LINE - 1));

    // Address steps by one word per beat
    assign wb_adr    = {line_base_q, beat, {(offset_w - sel_w){1'b0}}};
    assign fill_line = line_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc      <= 1'b0;
            wb_stb      <= 1'b0;
            line_done   <= 1'b0;
            beat        <= '0;
            line_base_q <= '0;
        end else begin
            line_done <= 1'b0;
            if (fill_start) begin
                wb_cyc      <= 1'b1;
                wb_stb      <= 1'b1;
                beat        <= '0;
                line_base_q <= fill_base[`ICACHE_ADDR_W-1:offset_w];
            end else if (wb_stb && wb_ack) begin
                if (last_beat) begin
                    wb_cyc    <= 1'b0;
                    wb_stb    <= 1'b0;
                    line_done <= 1'b1;
                end else begin
                    beat <= beat + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_stb && wb_ack) begin
            line_q[beat*`ICACHE_WORD_W +: `ICACHE_WORD_W] <= wb_dat_i;
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc
    ) else $error("wb_stb high outside a bus cycle");

endmodule

// File: src/icache_top.sv
//--------------------------------------------------------------------------
// Instruction cache top level: controller, tag/LRU store,
// data store and Wishbone line fill
//--------------------------------------------------------------------------

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  addr_t       req_addr,
    output logic        req_ready,
    output logic        resp_valid,
    output word_t       resp_data,
    output logic        wb_cyc,
    output logic        wb_stb,
    output addr_t       wb_adr,
    input  word_t       wb_dat_i,
    input  logic        wb_ack,
    output logic [31:0] hit_count,
    output logic [31:0] miss_count
);

    icache_lookup_if lookup_bus ();

    logic      fill_start;
    addr_t     fill_base;
    logic      line_done;
    line_t     fill_line;
    logic      wr_en;
    way_t      wr_way;
    line_t     wr_line;
    way_t      rd_way;
    word_sel_t rd_sel;
    word_t     rd_word;

    icache_ctrl icache_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .line_done  (line_done),
        .fill_line  (fill_line),
        .rd_word    (rd_word),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .wr_en      (wr_en),
        .wr_way     (wr_way),
        .wr_line    (wr_line),
        .rd_way     (rd_way),
        .rd_sel     (rd_sel),
        .hit_count  (hit_count),
        .miss_count (miss_count),
        .lookup     (lookup_bus.ctrl)
    );

    icache_tag_lru icache_tag_lru_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .lookup (lookup_bus.store)
    );

    // Both ports address the set held on the lookup bus
    icache_data_store icache_data_store_inst (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_set  (lookup_bus.index),
        .wr_way  (wr_way),
        .wr_line (wr_line),
        .rd_set  (lookup_bus.index),
        .rd_way  (rd_way),
        .rd_sel  (rd_sel),
        .rd_word (rd_word)
    );

    icache_line_fill icache_line_fill_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_start (fill_start),
        .fill_base  (fill_base),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .line_done  (line_done),
        .fill_line  (fill_line)
    );

endmodule

// File: testbench/icache_tb.sv
//--------------------------------------------------------------------------
// Instruction cache testbench: clock and reset, Wishbone memory model
// with random ack delay, requests from the test data file, checks
// and timeout
//--------------------------------------------------------------------------

module icache_tb
    import icache_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    addr_t       req_addr;
    logic        req_ready;
    logic        resp_valid;
    word_t       resp_data;
    logic        wb_cyc;
    logic        wb_stb;
    addr_t       wb_adr;
    word_t       wb_dat_i;
    logic        wb_ack;
    logic [31:0] hit_count;
    logic [31:0] miss_count;

    addr_t       req_list[$];
    logic        miss_list[$];
    int          errors = 0;
    int          cycle_limit = 0;
    int          cycles = 0;

    icache_top icache_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    // Backing memory content with the inverted address on top
    function automatic word_t mem_word(input addr_t a);
        return {~a, a};
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
    endtask

    task automatic load_testdata();
        int          fd;
        int          code;
        int          n;
        string       text;
        logic [15:0] a;
        logic [7:0]  c;
        fd = $fopen("testbench/icache_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open testbench/icache_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                code = $fgets(text, fd);
                n = (code == 0) ? 0 : $sscanf(text, "%h %c", a, c);
                if (n == 2 && (c == "H" || c == "M")) begin
                    req_list.push_back(a);
                    miss_list.push_back(c == "M");
                end else if (n == 2) begin
                    errors++;
                    $display("Test data line has no H or M marker: %s", text);
                end
            end
            $fclose(fd);
        end
        if (req_list.size() == 0) begin
            errors++;
            $display("No requests found in the test data file");
        end
    endtask

    // One request from issue to response with bus and timing checks
    task automatic run_request(input int idx, input addr_t addr, input logic exp_miss);
        addr_t base;
        addr_t exp_adr;
        word_t exp_word;
        logic  accepted;
        logic  done;
        logic  saw_cyc;
        int    edges;
        int    acks;
        int    last_ack;
        string name;
        base      = {addr[15:4], 4'h0};
        exp_word  = mem_word({addr[15:2], 2'b00});
        name      = $sformatf("req %0d @%h", idx, addr);
        accepted  = 1'b0;
        done      = 1'b0;
        saw_cyc   = 1'b0;
        edges     = 0;
        acks      = 0;
        last_ack  = 0;
        req_addr  <= addr;
        req_valid <= 1'b1;
        while (!accepted) begin
            @(posedge clk);
            accepted = req_ready;
        end
        req_valid <= 1'b0;
        while (!done) begin
            @(posedge clk);
            edges++;
            if (wb_cyc) begin
                saw_cyc = 1'b1;
            end
            if (wb_stb && wb_ack) begin
                exp_adr = base + addr_t'(acks * 4);
                if (wb_adr !== exp_adr) begin
                    report_mismatch({name, " wb_adr"}, exp_adr, wb_adr);
                end
                acks++;
                last_ack = edges;
            end
            done = resp_valid;
        end
        if (resp_data !== exp_word) begin
            report_mismatch({name, " data"}, exp_word, resp_data);
        end
        if (saw_cyc !== exp_miss) begin
            errors++;
            $display("[ERROR] %s hit/miss: expected %s, got %s", name,
                     exp_miss ? "M" : "H", saw_cyc ? "M" : "H");
        end
        if (saw_cyc) begin
            if (acks != 4) begin
                report_mismatch({name, " ack count"}, 4, acks);
            end
            if (edges - last_ack != 2) begin
                report_mismatch({name, " cycles after last ack"}, 2, edges - last_ack);
            end
        end else if (edges != 2) begin
            report_mismatch({name, " hit latency"}, 2, edges);
        end
    endtask

    //--------------------------------------------------------------------------
    // Clock, memory model and watchdog
    //--------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Single-read Wishbone slave with 0 to 3 wait cycles before each ack
    initial begin
        logic [31:0] rng;
        int          wait_left;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        rng       = lcg_next(32'hb4fb);
        wait_left = int'(rng[17:16]);
        forever begin
            @(posedge clk);
            if (wb_ack) begin
                wb_ack <= 1'b0;
            end else if (rst_n && wb_cyc && wb_stb) begin
                if (wait_left == 0) begin
                    wb_dat_i  <= mem_word(wb_adr);
                    wb_ack    <= 1'b1;
                    rng       = lcg_next(rng);
                    wait_left = int'(rng[17:16]);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    //--------------------------------------------------------------------------
    // Stimulus
    //--------------------------------------------------------------------------
    initial begin
        int exp_hits;
        int exp_misses;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        exp_hits   = 0;
        exp_misses = 0;
        load_testdata();
        cycle_limit = req_list.size() * 40 + 100;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Idle state straight after reset
        if (req_ready !== 1'b1) begin
            report_mismatch("reset req_ready", 1, req_ready);
        end
        if (resp_valid !== 1'b0 || wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
            errors++;
            $display("resp_valid, wb_cyc or wb_stb not low after reset");
        end
        if (hit_count !== 32'd0) begin
            report_mismatch("reset hit_count", 0, hit_count);
        end
        if (miss_count !== 32'd0) begin
            report_mismatch("reset miss_count", 0, miss_count);
        end

        for (int i = 0; i < req_list.size(); i++) begin
            run_request(i, req_list[i], miss_list[i]);
            if (miss_list[i]) begin
                exp_misses++;
            end else begin
                exp_hits++;
            end
        end
        @(posedge clk);

        if (hit_count !== 32'(exp_hits)) begin
            report_mismatch("final hit_count", exp_hits, hit_count);
        end
        if (miss_count !== 32'(exp_misses)) begin
            report_mismatch("final miss_count", exp_misses, miss_count);
        end

        $display("requests: %0d, errors: %0d", req_list.size(), errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: icache_top.f
+incdir+src
src/icache_pkg.sv
src/icache_lookup_if.sv
src/icache_ctrl.sv
src/icache_tag_lru.sv
src/icache_data_store.sv
src/icache_line_fill.sv
src/icache_top.sv
testbench/icache_tb.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

TOP := icache_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 -Wno-fatal --top-module $(TOP) \
		-f icache_top.f -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: testbench/icache_testdata.txt
// Byte address in hex, then the expected result: H for hit, M for miss
// One request per line, issued in file order after reset
0100 M
0100 H
0104 H
0108 H
010C H
0200 M
0300 M
0400 M
0104 H
0308 H
0500 M
0200 M
010C H
0304 H
0508 H
0204 H
0400 M
1234 M
1237 H
123C H
FFF0 M
FFFC H
00A8 M
8020 M
0100 M
